/* include/tb_check.svh */
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

// ==================================================
// shared fail path and value check
// ==================================================

// stops the run after a failure has been reported
task automatic report_failure();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on failure");
endtask

// compares one observed value against its expected value
task automatic check_value(
    input string       what,
    input logic [31:0] actual,
    input logic [31:0] expected
);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s got %0h, expected %0h", $time, what, actual, expected);
        report_failure();
    end
endtask

`endif

/* bench/colour_path_tb.sv */
module colour_path_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_check.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int CLKS_PER_PIX = 4;
    localparam int PIXEL_FIELDS = 15;

    logic                clk_24M = 1'b0;
    logic                reset;
    logic                pix_ce;
    colour_pkg::pen_t    fg_pen;
    logic                fg_enable;
    colour_pkg::pen_t    bg_pen;
    colour_pkg::bank_t   bg_bank_lo;
    colour_pkg::bank_t   bg_bank_hi;
    logic                bg_enable;
    logic                bg_hidden;
    colour_pkg::pen_t    spr_pen;
    colour_pkg::bank_t   spr_bank_lo;
    colour_pkg::bank_t   spr_bank_hi;
    logic                spr_enable;
    logic                blank;
    logic                ioctl_download;
    logic                ioctl_wr;
    logic [23:0]         ioctl_addr;
    logic [7:0]          ioctl_dout;
    colour_pkg::colour_t r;
    colour_pkg::colour_t g;
    colour_pkg::colour_t b;

    string       test_lines [$];
    // valid flag, then expected r, g, b
    logic [12:0] expect_q [$];
    int          expect_rec_q [$];
    bit          tests_loaded;

    always #(CLK_PERIOD / 2) clk_24M = ~clk_24M;

    colour_path colour_path_inst (
        .clk_24M        (clk_24M),
        .reset          (reset),
        .pix_ce         (pix_ce),
        .fg_pen         (fg_pen),
        .fg_enable      (fg_enable),
        .bg_pen         (bg_pen),
        .bg_bank_lo     (bg_bank_lo),
        .bg_bank_hi     (bg_bank_hi),
        .bg_enable      (bg_enable),
        .bg_hidden      (bg_hidden),
        .spr_pen        (spr_pen),
        .spr_bank_lo    (spr_bank_lo),
        .spr_bank_hi    (spr_bank_hi),
        .spr_enable     (spr_enable),
        .blank          (blank),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .r              (r),
        .g              (g),
        .b              (b)
    );

    // ==================================================
    // test file
    // ==================================================

    // keeps only D and P lines, comments and blank lines drop out
    task automatic load_tests();
        int    fd;
        int    code;
        string line;
        byte   kind;
        fd = $fopen("bench/colour_path_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file bench/colour_path_tests.txt");
            report_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0) begin
                    kind = line.getc(0);
                    if (kind == "D" || kind == "P") begin
                        test_lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ==================================================
    // drivers
    // ==================================================

    // drop the strobe, compare the pixel two strobes back
    task automatic finish_strobe();
        logic [12:0] exp;
        int          rec;
        @(negedge clk_24M);
        pix_ce = 1'b0;
        if (expect_q.size() == 3) begin
            exp = expect_q.pop_front();
            rec = expect_rec_q.pop_front();
            if (exp[12]) begin
                check_value($sformatf("record %0d red", rec), r, exp[11:8]);
                check_value($sformatf("record %0d green", rec), g, exp[7:4]);
                check_value($sformatf("record %0d blue", rec), b, exp[3:0]);
            end
        end
        repeat (CLKS_PER_PIX - 2) @(negedge clk_24M);
    endtask

    task automatic download_record(input string rest, input int rec);
        int dl;
        int addr;
        int data;
        int n;
        n = $sscanf(rest, "%h %h %h", dl, addr, data);
        if (n != 3) begin
            $display("download record %0d in the test file is malformed", rec);
            report_failure();
        end else begin
            @(negedge clk_24M);
            ioctl_download = dl[0];
            ioctl_wr       = 1'b1;
            ioctl_addr     = addr[23:0];
            ioctl_dout     = data[7:0];
            @(negedge clk_24M);
            ioctl_wr       = 1'b0;
            ioctl_download = 1'b0;
        end
    endtask

    task automatic pixel_record(input string rest, input int rec);
        int f [PIXEL_FIELDS];
        int n;
        n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (n != PIXEL_FIELDS) begin
            $display("pixel record %0d in the test file is malformed", rec);
            report_failure();
        end else begin
            @(negedge clk_24M);
            fg_pen      = f[0][3:0];
            fg_enable   = f[1][0];
            bg_pen      = f[2][3:0];
            bg_bank_lo  = f[3][1:0];
            bg_bank_hi  = f[4][1:0];
            bg_enable   = f[5][0];
            bg_hidden   = f[6][0];
            spr_pen     = f[7][3:0];
            spr_bank_lo = f[8][1:0];
            spr_bank_hi = f[9][1:0];
            spr_enable  = f[10][0];
            blank       = f[11][0];
            pix_ce      = 1'b1;
            expect_q.push_back({1'b1, f[12][3:0], f[13][3:0], f[14][3:0]});
            expect_rec_q.push_back(rec);
            finish_strobe();
        end
    endtask

    // two blanked strobes push the last pixels out
    task automatic flush_pipeline();
        repeat (2) begin
            @(negedge clk_24M);
            fg_enable  = 1'b0;
            spr_enable = 1'b0;
            blank      = 1'b1;
            pix_ce     = 1'b1;
            expect_q.push_back('0);
            expect_rec_q.push_back(-1);
            finish_strobe();
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        string line;
        reset          = 1'b1;
        pix_ce         = 1'b0;
        fg_pen         = '0;
        fg_enable      = 1'b0;
        bg_pen         = '0;
        bg_bank_lo     = '0;
        bg_bank_hi     = '0;
        bg_enable      = 1'b0;
        bg_hidden      = 1'b0;
        spr_pen        = '0;
        spr_bank_lo    = '0;
        spr_bank_hi    = '0;
        spr_enable     = 1'b0;
        blank          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;

        load_tests();
        tests_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk_24M);
        reset = 1'b0;
        @(negedge clk_24M);
        check_value("red after reset", r, 4'h0);
        check_value("green after reset", g, 4'h0);
        check_value("blue after reset", b, 4'h0);

        for (int i = 0; i < test_lines.size(); i++) begin
            line = test_lines[i];
            if (line.getc(0) == "D") begin
                download_record(line.substr(1, line.len() - 1), i + 1);
            end else begin
                pixel_record(line.substr(1, line.len() - 1), i + 1);
            end
        end
        flush_pipeline();

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // four clocks per record, plus room for reset and the flush
    initial begin
        wait (tests_loaded);
        #(test_lines.size() * CLKS_PER_PIX * CLK_PERIOD + 2000);
        $display("timeout: the test records did not finish in time");
        report_failure();
    end

endmodule

/* bench/colour_path_tests.txt */
# D download addr data : one ioctl write, download level, 24-bit address, byte
# P fg_pen fg_en bg_pen bg_lo bg_hi bg_en bg_hid spr_pen spr_lo spr_hi spr_en blank r g b
D 1 07E003 A1
D 1 07E103 52
D 1 07E203 F3
D 1 07E0D5 04
D 1 07E1D5 35
D 1 07E2D5 C6
D 1 07E096 27
D 1 07E196 98
D 1 07E296 09
D 1 07E0EA 6A
D 1 07E1EA 0B
D 1 07E2EA EC
D 1 07E0BB 1D
D 1 07E1BB 7E
D 1 07E2BB 8F
D 1 07E080 03
D 1 07E180 DC
D 1 07E280 45
D 1 07E007 5E
D 1 07E107 10
D 1 07E207 78
D 0 07E003 0E
D 1 07E303 0E
P 3 1 5 1 2 1 0 6 0 3 1 0 1 2 3
P F 1 5 1 2 1 0 0 0 3 1 0 4 5 6
P 3 0 5 1 2 1 0 6 1 3 1 0 7 8 9
P 3 0 A 1 2 1 0 6 0 3 0 0 A B C
P 3 0 5 1 2 1 0 B 0 3 1 0 D E F
P 3 0 5 1 2 1 1 0 0 3 1 0 3 C 5
P 3 0 5 1 2 0 0 0 0 3 1 0 3 C 5
P 3 1 5 1 2 1 0 6 0 3 1 1 0 0 0
P 7 1 5 1 2 1 0 6 0 3 1 0 E 0 8
P F 0 A 1 2 0 0 0 0 3 0 0 A B C
P 3 1 A 1 2 1 0 B 0 3 0 0 1 2 3

/* colour_path.f */
+incdir+include
rtl/colour_pkg.sv
rtl/prom_loader.sv
rtl/palette_prom.sv
rtl/layer_mixer.sv
rtl/rgb_output.sv
rtl/colour_path.sv
bench/colour_path_tb.sv

/* rtl/colour_path.sv */
module colour_path #(
    parameter int               NUM_PROMS        = colour_pkg::NUM_COLOUR_PROMS,
    parameter colour_pkg::pen_t SPRITE_TRANS_PEN = 4'd0
) (
    input  logic                clk_24M,
    input  logic                reset,
    input  logic                pix_ce,

    // foreground
    input  colour_pkg::pen_t    fg_pen,
    input  logic                fg_enable,

    // background
    input  colour_pkg::pen_t    bg_pen,
    input  colour_pkg::bank_t   bg_bank_lo,
    input  colour_pkg::bank_t   bg_bank_hi,
    input  logic                bg_enable,
    input  logic                bg_hidden,

    // sprites
    input  colour_pkg::pen_t    spr_pen,
    input  colour_pkg::bank_t   spr_bank_lo,
    input  colour_pkg::bank_t   spr_bank_hi,
    input  logic                spr_enable,

    input  logic                blank,

    // PROM download
    input  logic                ioctl_download,
    input  logic                ioctl_wr,
    input  logic [23:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,

    output colour_pkg::colour_t r,
    output colour_pkg::colour_t g,
    output colour_pkg::colour_t b
);

    logic [NUM_PROMS-1:0]   prom_we;
    colour_pkg::pal_index_t prom_addr;
    colour_pkg::colour_t    prom_data;
    colour_pkg::pal_index_t pal_idx;
    colour_pkg::colour_t    chan [NUM_PROMS];

    // ==================================================
    // download into the palette PROMs
    // ==================================================

    prom_loader #(
        .NUM_PROMS(NUM_PROMS)
    ) prom_loader_inst (
        .clk_24M        (clk_24M),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .prom_we        (prom_we),
        .prom_addr      (prom_addr),
        .prom_data      (prom_data)
    );

    // one PROM per colour channel, all looked up with the same index
    for (genvar n = 0; n < NUM_PROMS; n++) begin : g_prom
        palette_prom palette_prom_inst (
            .clk_24M (clk_24M),
            .we      (prom_we[n]),
            .wr_addr (prom_addr),
            .wr_data (prom_data),
            .rd_addr (pal_idx),
            .rd_data (chan[n])
        );
    end

    // ==================================================
    // pixel path
    // ==================================================

    layer_mixer #(
        .SPRITE_TRANS_PEN(SPRITE_TRANS_PEN)
    ) layer_mixer_inst (
        .clk_24M     (clk_24M),
        .reset       (reset),
        .pix_ce      (pix_ce),
        .fg_pen      (fg_pen),
        .fg_enable   (fg_enable),
        .bg_pen      (bg_pen),
        .bg_bank_lo  (bg_bank_lo),
        .bg_bank_hi  (bg_bank_hi),
        .bg_enable   (bg_enable),
        .bg_hidden   (bg_hidden),
        .spr_pen     (spr_pen),
        .spr_bank_lo (spr_bank_lo),
        .spr_bank_hi (spr_bank_hi),
        .spr_enable  (spr_enable),
        .pal_idx     (pal_idx)
    );

    rgb_output #(
        .NUM_PROMS(NUM_PROMS)
    ) rgb_output_inst (
        .clk_24M (clk_24M),
        .reset   (reset),
        .pix_ce  (pix_ce),
        .blank   (blank),
        .chan    (chan),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

/* rtl/colour_pkg.sv */
package colour_pkg;

    // ==================================================
    // pixel and colour types
    // ==================================================

    // pen within one 16-colour palette
    typedef logic [3:0] pen_t;

    // palette bank selector
    typedef logic [1:0] bank_t;

    // full palette index, also the PROM address
    typedef logic [7:0] pal_index_t;

    // one colour channel
    typedef logic [3:0] colour_t;

    // ==================================================
    // palette PROMs
    // ==================================================

    localparam int PROM_DEPTH = 256;

    // red, green, blue
    localparam int NUM_COLOUR_PROMS = 3;

    // download windows, one per PROM, back to back
    localparam logic [23:0] PROM_WINDOW_BASE   = 24'h07E000;
    localparam logic [23:0] PROM_WINDOW_STRIDE = 24'h000100;

    // ==================================================
    // layer encoding
    // ==================================================

    // foreground pen that lets lower layers through
    localparam pen_t FG_TRANSPARENT_PEN = 4'd15;

    // top two index bits per layer
    // foreground indices start with four zero bits instead
    localparam logic [1:0] BG_INDEX_PREFIX  = 2'b11;
    localparam logic [1:0] SPR_INDEX_PREFIX = 2'b10;

endpackage

/* rtl/layer_mixer.sv */
module layer_mixer #(
    parameter colour_pkg::pen_t SPRITE_TRANS_PEN = 4'd0
) (
    input  logic                   clk_24M,
    input  logic                   reset,
    input  logic                   pix_ce,

    // foreground layer
    input  colour_pkg::pen_t       fg_pen,
    input  logic                   fg_enable,

    // background layer
    input  colour_pkg::pen_t       bg_pen,
    input  colour_pkg::bank_t      bg_bank_lo,
    input  colour_pkg::bank_t      bg_bank_hi,
    input  logic                   bg_enable,
    input  logic                   bg_hidden,

    // sprite layer
    input  colour_pkg::pen_t       spr_pen,
    input  colour_pkg::bank_t      spr_bank_lo,
    input  colour_pkg::bank_t      spr_bank_hi,
    input  logic                   spr_enable,

    output colour_pkg::pal_index_t pal_idx
);

    // ==================================================
    // stage one, candidate indices
    // ==================================================

    colour_pkg::bank_t      bg_bank;
    colour_pkg::bank_t      spr_bank;

    colour_pkg::pal_index_t fg_idx_r;
    colour_pkg::pal_index_t bg_idx_r;
    colour_pkg::pal_index_t spr_idx_r;
    logic                   spr_transp_r;
    logic                   fg_enable_r;
    logic                   bg_enable_r;
    logic                   bg_hidden_r;
    logic                   spr_enable_r;

    // pen bit 3 picks the upper bank
    assign bg_bank  = bg_pen[3] ? bg_bank_hi : bg_bank_lo;
    assign spr_bank = spr_pen[3] ? spr_bank_hi : spr_bank_lo;

    always_ff @(posedge clk_24M) begin
        if (pix_ce) begin
            fg_idx_r     <= {4'b0000, fg_pen};
            bg_idx_r     <= {colour_pkg::BG_INDEX_PREFIX, bg_bank, bg_pen};
            spr_idx_r    <= {colour_pkg::SPR_INDEX_PREFIX, spr_bank, spr_pen};
            spr_transp_r <= (spr_pen == SPRITE_TRANS_PEN);
        end
    end

    // layer controls follow their pixel down the pipe
    always_ff @(posedge clk_24M) begin
        if (reset) begin
            fg_enable_r  <= 1'b0;
            bg_enable_r  <= 1'b0;
            bg_hidden_r  <= 1'b0;
            spr_enable_r <= 1'b0;
        end else if (pix_ce) begin
            fg_enable_r  <= fg_enable;
            bg_enable_r  <= bg_enable;
            bg_hidden_r  <= bg_hidden;
            spr_enable_r <= spr_enable;
        end
    end

    // ==================================================
    // stage two, priority
    // ==================================================

    logic fg_opaque;
    logic bg_wins;

    assign fg_opaque = fg_enable_r && (fg_idx_r[3:0] != colour_pkg::FG_TRANSPARENT_PEN);

    // background shows through a see-through sprite, or when sprites are off
    assign bg_wins = !spr_enable_r || (bg_enable_r && spr_transp_r && !bg_hidden_r);

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            pal_idx <= '0;
        end else if (pix_ce) begin
            if (fg_opaque) begin
                pal_idx <= fg_idx_r;
            end else if (bg_wins) begin
                pal_idx <= bg_idx_r;
            end else begin
                pal_idx <= spr_idx_r;
            end
        end
    end

    // the PROM lookup needs a free clock between pixels
    a_pix_ce_spacing : assert property (
        @(posedge clk_24M) disable iff (reset)
        pix_ce |=> !pix_ce
    ) else $error("pixel strobe on two consecutive clocks");

endmodule

/* rtl/palette_prom.sv */
module palette_prom (
    input  logic                   clk_24M,

    // download side
    input  logic                   we,
    input  colour_pkg::pal_index_t wr_addr,
    input  colour_pkg::colour_t    wr_data,

    // pixel lookup side
    input  colour_pkg::pal_index_t rd_addr,
    output colour_pkg::colour_t    rd_data
);

    // one colour channel for every palette index
    colour_pkg::colour_t mem [colour_pkg::PROM_DEPTH];

    always_ff @(posedge clk_24M) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // lookup runs every clock
    // one clock from rd_addr to rd_data
    always_ff @(posedge clk_24M) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/prom_loader.sv */
module prom_loader #(
    parameter int NUM_PROMS = colour_pkg::NUM_COLOUR_PROMS
) (
    input  logic                   clk_24M,
    input  logic                   reset,

    // byte-wide download port
    input  logic                   ioctl_download,
    input  logic                   ioctl_wr,
    input  logic [23:0]            ioctl_addr,
    input  logic [7:0]             ioctl_dout,

    // shared write bus to the PROMs
    output logic [NUM_PROMS-1:0]   prom_we,
    output colour_pkg::pal_index_t prom_addr,
    output colour_pkg::colour_t    prom_data
);

    // ==================================================
    // window decode
    // ==================================================

    logic                   wr_valid;
    logic [NUM_PROMS-1:0]   window_hit;
    logic [23:0]            window_offset;

    assign wr_valid = ioctl_download && ioctl_wr;

    // offset into the whole PROM area, low bits give the entry
    assign window_offset = ioctl_addr - colour_pkg::PROM_WINDOW_BASE;

    for (genvar n = 0; n < NUM_PROMS; n++) begin : g_window
        localparam logic [23:0] WIN_LO =
            colour_pkg::PROM_WINDOW_BASE + 24'(n) * colour_pkg::PROM_WINDOW_STRIDE;
        localparam logic [23:0] WIN_HI = WIN_LO + colour_pkg::PROM_WINDOW_STRIDE;

        assign window_hit[n] = wr_valid && (ioctl_addr >= WIN_LO) && (ioctl_addr < WIN_HI);
    end

    // ==================================================
    // registered write strobe
    // ==================================================

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            prom_we <= '0;
        end else begin
            prom_we <= window_hit;
        end
    end

    // entry and data only matter while a strobe is up
    always_ff @(posedge clk_24M) begin
        prom_addr <= window_offset[$bits(colour_pkg::pal_index_t)-1:0];
        // palette PROMs are 4 bits wide
        prom_data <= ioctl_dout[$bits(colour_pkg::colour_t)-1:0];
    end

    // windows never overlap, so at most one PROM is written
    a_we_onehot : assert property (
        @(posedge clk_24M) disable iff (reset)
        $onehot0(prom_we)
    ) else $error("more than one palette PROM write strobe active");

endmodule

/* rtl/rgb_output.sv */
module rgb_output #(
    parameter int NUM_PROMS = colour_pkg::NUM_COLOUR_PROMS
) (
    input  logic                clk_24M,
    input  logic                reset,
    input  logic                pix_ce,
    input  logic                blank,

    // PROM lookup results, red first
    input  colour_pkg::colour_t chan [NUM_PROMS],

    output colour_pkg::colour_t r,
    output colour_pkg::colour_t g,
    output colour_pkg::colour_t b
);

    // blank sampled with the pixel, two strobes behind
    logic [1:0] blank_d;

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            blank_d <= 2'b11;
        end else if (pix_ce) begin
            blank_d <= {blank_d[0], blank};
        end
    end

    // ==================================================
    // colour register
    // ==================================================

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else if (pix_ce) begin
            if (blank_d[1]) begin
                r <= '0;
                g <= '0;
                b <= '0;
            end else begin
                r <= chan[0];
                g <= chan[1];
                b <= chan[2];
            end
        end
    end

    // blanked pixel leaves the output dark
    a_blank_black : assert property (
        @(posedge clk_24M) disable iff (reset)
        (pix_ce && blank_d[1]) |=> (r == '0 && g == '0 && b == '0)
    ) else $error("colour output not black for a blanked pixel");

endmodule
